// File: verilog/fetch_params.svh
/*
 * fetch front end parameters
 * bundle geometry, pc width, btb indexing and the
 * branch opcodes recognized by the f1 predecoder
 */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// pc and instruction geometry
`define FETCH_PC_W          64
`define FETCH_INST_W        32
`define FETCH_SLOTS         8
`define FETCH_SLOT_W        3
`define FETCH_BUNDLE_W      (`FETCH_SLOTS * `FETCH_INST_W)
`define FETCH_BUNDLE_BYTES  32

// btb: direct mapped, indexed above the bundle offset
`define BTB_ENTRIES         16
`define BTB_IDX_W           4
`define BTB_IDX_LSB         5
`define BTB_TAG_W           12
`define BTB_TAG_LSB         (`BTB_IDX_LSB + `BTB_IDX_W)

// opcode field sits in inst[31:26]
`define OP_W                6
`define OP_BR               6'h30
`define OP_BEQ              6'h39
`define BR_DISP_W           21

`endif

// File: verilog/fetch_pkg.sv
/*
 * fetch front end types
 * branch classes, the btb entry layout and the
 * record carried from stage f0 to stage f1
 */
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

  typedef enum logic [1:0] {
    BR_NONE   = 2'd0,
    BR_COND   = 2'd1,
    BR_UNCOND = 2'd2
  } br_type_e;

  // one btb line, about 83 bits
  typedef struct packed {
    logic                     valid;
    logic [`BTB_TAG_W-1:0]    tag;
    logic [`FETCH_SLOT_W-1:0] pos;
    br_type_e                 br_type;
    logic                     taken;
    logic [`FETCH_PC_W-1:0]   target;
  } btb_entry_t;

  // f0 prediction as seen by f1
  typedef struct packed {
    logic                     hit;
    logic                     taken;
    logic [`FETCH_SLOT_W-1:0] pos;
    logic [`FETCH_PC_W-1:0]   target;
    logic [`FETCH_SLOTS-1:0]  keep;
  } f0_pipe_t;

endpackage

`default_nettype wire

// File: verilog/btb_wr_if.sv
/*
 * btb write request
 * single cycle strobe with index, entry and a
 * direction-only flag, no back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

interface btb_wr_if;
  import fetch_pkg::*;

  logic                   req;
  logic [`BTB_IDX_W-1:0]  idx;
  btb_entry_t             entry;
  // only the taken bit of a matching entry changes
  logic                   dir_only;

  modport requester (
    output req,
    output idx,
    output entry,
    output dir_only
  );

  modport arbiter (
    input  req,
    input  idx,
    input  entry,
    input  dir_only
  );

endinterface

`default_nettype wire

// File: verilog/btb_table.sv
/*
 * branch target buffer storage
 * direct mapped, combinational lookup for f0 and
 * one registered write port fed by the write arbiter
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module btb_table (
  input  wire                      clock,
  input  wire                      reset_n,
  input  wire [`FETCH_PC_W-1:0]    lookup_pc_i,
  output logic                     hit_o,
  output fetch_pkg::btb_entry_t    entry_o,
  btb_wr_if.arbiter                wr
);
  import fetch_pkg::*;

  logic [`BTB_ENTRIES-1:0] valid_q;
  btb_entry_t              mem_q [`BTB_ENTRIES];

  logic [`BTB_IDX_W-1:0]   lookup_idx;
  logic [`BTB_TAG_W-1:0]   lookup_tag;
  logic                    wr_tag_match;

  ////////////////////
  // f0 lookup
  ////////////////////
  assign lookup_idx = lookup_pc_i[`BTB_IDX_LSB +: `BTB_IDX_W];
  assign lookup_tag = lookup_pc_i[`BTB_TAG_LSB +: `BTB_TAG_W];

  always_comb begin
    entry_o       = mem_q[lookup_idx];
    entry_o.valid = valid_q[lookup_idx];
    hit_o         = valid_q[lookup_idx] && (mem_q[lookup_idx].tag == lookup_tag);
  end

  ////////////////////
  // write port
  ////////////////////
  // a direction update only lands on a live entry with the same tag
  assign wr_tag_match = valid_q[wr.idx] && (mem_q[wr.idx].tag == wr.entry.tag);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= '0;
    end else if (wr.req && !wr.dir_only) begin
      valid_q[wr.idx] <= wr.entry.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (wr.req) begin
      if (wr.dir_only) begin
        if (wr_tag_match) begin
          mem_q[wr.idx].taken <= wr.entry.taken;
        end
      end else begin
        mem_q[wr.idx] <= wr.entry;
      end
    end
  end

  // arbiter output must be quiet while the table is in reset
  a_no_write_in_reset : assert property (
    @(posedge clock) !reset_n |-> !wr.req
  ) else $error("btb write issued during reset");

endmodule

`default_nettype wire

// File: verilog/btb_write_arbiter.sv
/*
 * btb write arbiter
 * fixed priority with retire ahead of the predecode fill
 * the winner is registered for one cycle and the loser dropped
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module btb_write_arbiter (
  input  wire          clock,
  input  wire          reset_n,
  btb_wr_if.arbiter    rt_wr,
  btb_wr_if.arbiter    pd_wr,
  btb_wr_if.requester  wr_o
);
  import fetch_pkg::*;

  // grant_q[1] is retire and grant_q[0] is predecode
  logic [1:0]            grant_q;
  logic [`BTB_IDX_W-1:0] idx_q;
  btb_entry_t            entry_q;
  logic                  dir_only_q;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      grant_q <= 2'b00;
    end else begin
      grant_q <= {rt_wr.req, pd_wr.req && !rt_wr.req};
    end
  end

  always_ff @(posedge clock) begin
    if (rt_wr.req) begin
      idx_q      <= rt_wr.idx;
      entry_q    <= rt_wr.entry;
      dir_only_q <= rt_wr.dir_only;
    end else begin
      idx_q      <= pd_wr.idx;
      entry_q    <= pd_wr.entry;
      dir_only_q <= pd_wr.dir_only;
    end
  end

  assign wr_o.req      = |grant_q;
  assign wr_o.idx      = idx_q;
  assign wr_o.entry    = entry_q;
  assign wr_o.dir_only = dir_only_q;

  // retire only sends direction updates and predecode only sends full fills
  a_single_source : assert property (
    @(posedge clock) disable iff (!reset_n)
    (|grant_q) |-> (dir_only_q == grant_q[1])
  ) else $error("btb write payload does not belong to the granted source");

endmodule

`default_nettype wire

// File: verilog/fetch_predict_f0.sv
/*
 * fetch stage f0 prediction
 * picks the next fetch pc from the btb result,
 * builds the slot keep mask and loads the f0 to f1 pipe
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_predict_f0 (
  input  wire                     clock,
  input  wire                     reset_n,
  input  wire [`FETCH_PC_W-1:0]   pc_f0_i,
  input  wire                     load_fetch_i,
  input  wire                     icache_stall_i,
  input  wire                     btb_hit_i,
  input  fetch_pkg::btb_entry_t   btb_entry_i,
  output logic [`FETCH_PC_W-1:0]  lookup_pc_o,
  output logic [`FETCH_PC_W-1:0]  branch_pc_o,
  output fetch_pkg::f0_pipe_t     f1_o,
  output logic                    stall_f1_o
);
  import fetch_pkg::*;

  logic [`FETCH_SLOT_W:0]  nt_slots;
  logic [`FETCH_SLOTS-1:0] keep_mask;
  f0_pipe_t                f1_d;

  assign lookup_pc_o = pc_f0_i;

  ////////////////////
  // next pc
  ////////////////////
  // not taken resumes right after the branch slot
  assign nt_slots = {1'b0, btb_entry_i.pos} + (`FETCH_SLOT_W+1)'(1);

  always_comb begin
    if (btb_hit_i && btb_entry_i.taken) begin
      branch_pc_o = btb_entry_i.target;
    end else if (btb_hit_i) begin
      branch_pc_o = pc_f0_i + `FETCH_PC_W'({nt_slots, 2'b00});
    end else begin
      branch_pc_o = pc_f0_i + `FETCH_PC_W'(`FETCH_BUNDLE_BYTES);
    end
  end

  // keep slots up to and including the predicted branch
  always_comb begin
    for (int i = 0; i < `FETCH_SLOTS; i++) begin
      keep_mask[i] = !btb_hit_i || (`FETCH_SLOT_W'(i) <= btb_entry_i.pos);
    end
  end

  always_comb begin
    f1_d.hit    = btb_hit_i;
    f1_d.taken  = btb_hit_i && btb_entry_i.taken;
    f1_d.pos    = btb_entry_i.pos;
    f1_d.target = btb_entry_i.target;
    f1_d.keep   = keep_mask;
  end

  ////////////////////
  // f0 to f1 pipe
  ////////////////////
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      f1_o       <= '0;
      stall_f1_o <= 1'b0;
    end else if (load_fetch_i) begin
      f1_o       <= f1_d;
      stall_f1_o <= icache_stall_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/branch_predecode.sv
/*
 * fetch stage f1 predecode
 * finds the first kept branch in the bundle, overrides f0
 * when it predicts taken and f0 did not, requests a btb fill
 * and registers the surviving bundle toward decode
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module branch_predecode (
  input  wire                        clock,
  input  wire                        reset_n,
  input  wire [`FETCH_PC_W-1:0]      pc_f1_i,
  input  wire [`FETCH_BUNDLE_W-1:0]  inst_bundle_i,
  input  fetch_pkg::f0_pipe_t        f1_i,
  input  wire                        stall_f1_i,
  input  wire                        load_fetch_i,
  input  wire                        flush_i,
  btb_wr_if.requester                pd_wr,
  output logic                       override_vld_o,
  output logic [`FETCH_PC_W-1:0]     override_pc_o,
  output logic [`FETCH_BUNDLE_W-1:0] inst_o,
  output logic [`FETCH_SLOTS-1:0]    inst_vld_o
);
  import fetch_pkg::*;

  logic                     flush_q;
  logic                     override_q;
  logic                     squash;

  logic                     br_found;
  br_type_e                 br_type;
  logic [`FETCH_SLOT_W-1:0] br_pos;
  logic [`BR_DISP_W-1:0]    br_disp;
  logic [`FETCH_SLOT_W:0]   next_slot;
  logic [`FETCH_PC_W-1:0]   br_target;
  logic                     pred_taken;
  logic                     f0_agrees;
  logic [`FETCH_SLOTS-1:0]  slot_vld;
  btb_entry_t               fill_entry;

  assign squash = !load_fetch_i || stall_f1_i || flush_i || flush_q || override_q;

  ////////////////////
  // branch scan
  ////////////////////
  // walk down so the lowest kept branch wins
  always_comb begin
    logic [`FETCH_INST_W-1:0] inst;
    br_found = 1'b0;
    br_type  = BR_NONE;
    br_pos   = '0;
    br_disp  = '0;
    for (int i = `FETCH_SLOTS - 1; i >= 0; i--) begin
      inst = inst_bundle_i[i*`FETCH_INST_W +: `FETCH_INST_W];
      if (f1_i.keep[i] && (inst[`FETCH_INST_W-1 -: `OP_W] == `OP_BR ||
                           inst[`FETCH_INST_W-1 -: `OP_W] == `OP_BEQ)) begin
        br_found = 1'b1;
        br_type  = (inst[`FETCH_INST_W-1 -: `OP_W] == `OP_BR) ? BR_UNCOND : BR_COND;
        br_pos   = `FETCH_SLOT_W'(i);
        br_disp  = inst[`BR_DISP_W-1:0];
      end
    end
  end

  // target relative to the instruction after the branch
  assign next_slot = {1'b0, br_pos} + (`FETCH_SLOT_W+1)'(1);
  assign br_target = pc_f1_i + `FETCH_PC_W'({next_slot, 2'b00})
                   + {{(`FETCH_PC_W-`BR_DISP_W-2){br_disp[`BR_DISP_W-1]}}, br_disp, 2'b00};

  // backward conditional branches are guessed taken
  assign pred_taken = br_found && (br_type == BR_UNCOND || br_disp[`BR_DISP_W-1]);
  assign f0_agrees  = f1_i.hit && f1_i.taken && (f1_i.pos == br_pos)
                   && (f1_i.target == br_target);

  assign override_vld_o = pred_taken && !f0_agrees && !squash;
  assign override_pc_o  = br_target;

  // drop slots behind an overriding branch
  always_comb begin
    for (int i = 0; i < `FETCH_SLOTS; i++) begin
      slot_vld[i] = f1_i.keep[i] && !squash
                 && (!override_vld_o || `FETCH_SLOT_W'(i) <= br_pos);
    end
  end

  ////////////////////
  // btb fill
  ////////////////////
  always_comb begin
    fill_entry.valid   = 1'b1;
    fill_entry.tag     = pc_f1_i[`BTB_TAG_LSB +: `BTB_TAG_W];
    fill_entry.pos     = br_pos;
    fill_entry.br_type = br_type;
    fill_entry.taken   = 1'b1;
    fill_entry.target  = br_target;
  end

  assign pd_wr.req      = override_vld_o;
  assign pd_wr.idx      = pc_f1_i[`BTB_IDX_LSB +: `BTB_IDX_W];
  assign pd_wr.entry    = fill_entry;
  assign pd_wr.dir_only = 1'b0;

  ////////////////////
  // history and decode register
  ////////////////////
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      flush_q    <= 1'b0;
      override_q <= 1'b0;
      inst_vld_o <= '0;
    end else begin
      flush_q    <= flush_i;
      override_q <= override_vld_o;
      if (load_fetch_i) begin
        inst_vld_o <= slot_vld;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load_fetch_i) begin
      inst_o <= inst_bundle_i;
    end
  end

  // the bundle after an override or a flush is always squashed
  a_no_override_when_squashed : assert property (
    @(posedge clock) disable iff (!reset_n)
    (override_vld_o || flush_i) |=> !override_vld_o
  ) else $error("override raised in a squashed f1 cycle");

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
/*
 * two stage instruction fetch front end
 * f0 btb prediction, f1 predecode override and the
 * retire direction update, all sharing one btb
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_top (
  input  wire                        clock,
  input  wire                        reset_n,
  input  wire [`FETCH_PC_W-1:0]      pc_f0_i,
  input  wire [`FETCH_PC_W-1:0]      pc_f1_i,
  input  wire [`FETCH_BUNDLE_W-1:0]  inst_bundle_i,
  input  wire                        icache_stall_i,
  input  wire                        instbuf_full_i,
  input  wire                        flush_i,
  input  wire                        rt_update_i,
  input  wire [`FETCH_PC_W-1:0]      rt_pc_i,
  input  wire                        rt_taken_i,
  output logic [`FETCH_PC_W-1:0]     branch_pc_o,
  output logic                       override_vld_o,
  output logic [`FETCH_PC_W-1:0]     override_pc_o,
  output logic [`FETCH_BUNDLE_W-1:0] inst_o,
  output logic [`FETCH_SLOTS-1:0]    inst_vld_o
);
  import fetch_pkg::*;

  logic                   load_fetch;
  logic [`FETCH_PC_W-1:0] lookup_pc;
  logic                   btb_hit;
  btb_entry_t             btb_entry;
  f0_pipe_t               f1_pipe;
  logic                   stall_f1;

  logic                   rt_update_q;
  logic [`FETCH_PC_W-1:0] rt_pc_q;
  logic                   rt_taken_q;
  btb_entry_t             rt_entry;

  btb_wr_if rt_wr ();
  btb_wr_if pd_wr ();
  btb_wr_if arb_wr ();

  // fetch moves unless the instruction buffer is full, flush always wins
  assign load_fetch = !instbuf_full_i || flush_i;

  ////////////////////
  // retire update
  ////////////////////
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      rt_update_q <= 1'b0;
    end else begin
      rt_update_q <= rt_update_i;
    end
  end

  always_ff @(posedge clock) begin
    rt_pc_q    <= rt_pc_i;
    rt_taken_q <= rt_taken_i;
  end

  // only tag and taken matter for a direction write
  always_comb begin
    rt_entry         = '0;
    rt_entry.valid   = 1'b1;
    rt_entry.tag     = rt_pc_q[`BTB_TAG_LSB +: `BTB_TAG_W];
    rt_entry.br_type = BR_NONE;
    rt_entry.taken   = rt_taken_q;
  end

  assign rt_wr.req      = rt_update_q;
  assign rt_wr.idx      = rt_pc_q[`BTB_IDX_LSB +: `BTB_IDX_W];
  assign rt_wr.entry    = rt_entry;
  assign rt_wr.dir_only = 1'b1;

  ////////////////////
  // instances
  ////////////////////
  fetch_predict_f0 u_f0 (
    .clock          (clock),
    .reset_n        (reset_n),
    .pc_f0_i        (pc_f0_i),
    .load_fetch_i   (load_fetch),
    .icache_stall_i (icache_stall_i),
    .btb_hit_i      (btb_hit),
    .btb_entry_i    (btb_entry),
    .lookup_pc_o    (lookup_pc),
    .branch_pc_o    (branch_pc_o),
    .f1_o           (f1_pipe),
    .stall_f1_o     (stall_f1)
  );

  branch_predecode u_f1 (
    .clock          (clock),
    .reset_n        (reset_n),
    .pc_f1_i        (pc_f1_i),
    .inst_bundle_i  (inst_bundle_i),
    .f1_i           (f1_pipe),
    .stall_f1_i     (stall_f1),
    .load_fetch_i   (load_fetch),
    .flush_i        (flush_i),
    .pd_wr          (pd_wr),
    .override_vld_o (override_vld_o),
    .override_pc_o  (override_pc_o),
    .inst_o         (inst_o),
    .inst_vld_o     (inst_vld_o)
  );

  btb_write_arbiter u_arb (
    .clock   (clock),
    .reset_n (reset_n),
    .rt_wr   (rt_wr),
    .pd_wr   (pd_wr),
    .wr_o    (arb_wr)
  );

  btb_table u_btb (
    .clock       (clock),
    .reset_n     (reset_n),
    .lookup_pc_i (lookup_pc),
    .hit_o       (btb_hit),
    .entry_o     (btb_entry),
    .wr          (arb_wr)
  );

endmodule

`default_nettype wire

// File: verif/clock_gen.sv
/*
 * testbench clock and reset
 * free running clock and an active low reset that
 * is released on a falling edge after a fixed count
 */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int half_period_ns = 20,
  parameter int reset_cycles   = 16
) (
  output logic clock_o,
  output logic reset_n_o
);

  initial begin
    clock_o = 1'b0;
    forever #(half_period_ns) clock_o = ~clock_o;
  end

  // release away from the rising edge
  initial begin
    reset_n_o = 1'b0;
    repeat (reset_cycles) @(posedge clock_o);
    @(negedge clock_o);
    reset_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/fetch_tb.sv
/*
 * fetch front end testbench
 * drives f0 and f1 fetch traffic on the falling edge and
 * arms expected values per cycle for the concurrent
 * assertions that compare them against the DUT
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_tb;

  localparam int clk_period = 40;
  localparam int wait_limit = 16;
  localparam int reset_limit = 64;

  logic clock;
  logic reset_n;
  logic [`FETCH_PC_W-1:0] pc_f0_i, pc_f1_i, rt_pc_i;
  logic [`FETCH_BUNDLE_W-1:0] inst_bundle_i;
  logic icache_stall_i, instbuf_full_i, flush_i, rt_update_i, rt_taken_i;
  logic [`FETCH_PC_W-1:0] branch_pc_o, override_pc_o;
  logic override_vld_o;
  logic [`FETCH_BUNDLE_W-1:0] inst_o;
  logic [`FETCH_SLOTS-1:0] inst_vld_o;

  // reference bookkeeping
  logic [`FETCH_PC_W-1:0] f1_pc;
  logic chk_next_pc, chk_ovr, exp_ovr, chk_inst, chk_hold, chk_quiet;
  logic [`FETCH_PC_W-1:0] exp_next_pc, exp_ovr_pc;
  logic [`FETCH_BUNDLE_W-1:0] exp_inst;
  logic [`FETCH_SLOTS-1:0] exp_vld;
  int armed_next_pc, armed_ovr, armed_inst, armed_hold, armed_quiet;

  logic [`FETCH_PC_W-1:0] pc_a, pc_b, pc_c, pc_d, pc_e, tgt_b, tgt_c, tgt_d;
  logic [`FETCH_BUNDLE_W-1:0] bundle_a, bundle_b, bundle_c, bundle_d, bundle_e;

  clock_gen #(.half_period_ns(clk_period / 2), .reset_cycles(16)) u_clk (
    .clock_o   (clock),
    .reset_n_o (reset_n)
  );

  fetch_top dut (
    .clock          (clock),
    .reset_n        (reset_n),
    .pc_f0_i        (pc_f0_i),
    .pc_f1_i        (pc_f1_i),
    .inst_bundle_i  (inst_bundle_i),
    .icache_stall_i (icache_stall_i),
    .instbuf_full_i (instbuf_full_i),
    .flush_i        (flush_i),
    .rt_update_i    (rt_update_i),
    .rt_pc_i        (rt_pc_i),
    .rt_taken_i     (rt_taken_i),
    .branch_pc_o    (branch_pc_o),
    .override_vld_o (override_vld_o),
    .override_pc_o  (override_pc_o),
    .inst_o         (inst_o),
    .inst_vld_o     (inst_vld_o)
  );

  ////////////////////
  // failure reporting
  ////////////////////
  task automatic end_in_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_error(input string msg);
    $display("** Error (%0t ns): %s", $time, msg);
    end_in_failure();
  endtask

  task automatic timeout_error(input string what);
    $display("timed out waiting for %s", what);
    end_in_failure();
  endtask

  ////////////////////
  // stimulus helpers
  ////////////////////
  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = $urandom();
    // keep the opcode off both branch encodings
    if (w[31:26] == `OP_BR || w[31:26] == `OP_BEQ) begin
      w[26] = ~w[26];
    end
    return w;
  endfunction

  function automatic logic [`FETCH_BUNDLE_W-1:0] filler_bundle();
    logic [`FETCH_BUNDLE_W-1:0] b;
    for (int i = 0; i < `FETCH_SLOTS; i++) begin
      b[i*32 +: 32] = random_word();
    end
    return b;
  endfunction

  // opcode with ra fixed to r31 and a 21-bit instruction displacement
  function automatic logic [31:0] branch_word(input logic [5:0] op, input int disp);
    return {op, 5'd31, 21'(disp)};
  endfunction

  function automatic logic [`FETCH_BUNDLE_W-1:0] place_word(
    input logic [`FETCH_BUNDLE_W-1:0] b, input int slot, input logic [31:0] w);
    logic [`FETCH_BUNDLE_W-1:0] r;
    r = b;
    r[slot*32 +: 32] = w;
    return r;
  endfunction

  // displacement counts from the instruction after the branch
  function automatic logic [`FETCH_PC_W-1:0] branch_target(
    input logic [`FETCH_PC_W-1:0] pc, input int slot, input int disp);
    return pc + 64'(4 * (slot + 1)) + 64'(longint'(disp) * 4);
  endfunction

  task automatic drive(input logic [`FETCH_PC_W-1:0] pc0,
                       input logic [`FETCH_BUNDLE_W-1:0] bundle,
                       input logic full, input logic flush);
    @(negedge clock);
    chk_next_pc = 1'b0;
    chk_ovr = 1'b0;
    chk_inst = 1'b0;
    chk_hold = 1'b0;
    chk_quiet = 1'b0;
    rt_update_i = 1'b0;
    pc_f0_i = pc0;
    pc_f1_i = f1_pc;
    inst_bundle_i = bundle;
    instbuf_full_i = full;
    flush_i = flush;
    if (!full || flush) begin
      f1_pc = pc0;
    end
  endtask

  task automatic expect_next_pc(input logic [`FETCH_PC_W-1:0] pc);
    chk_next_pc = 1'b1;
    exp_next_pc = pc;
    armed_next_pc++;
  endtask

  task automatic expect_override(input logic vld, input logic [`FETCH_PC_W-1:0] pc);
    chk_ovr = 1'b1;
    exp_ovr = vld;
    exp_ovr_pc = pc;
    armed_ovr++;
  endtask

  task automatic expect_inst(input logic [`FETCH_BUNDLE_W-1:0] b,
                             input logic [`FETCH_SLOTS-1:0] vld);
    chk_inst = 1'b1;
    exp_inst = b;
    exp_vld = vld;
    armed_inst++;
  endtask

  // keep fetching pc until the btb gives the expected next pc
  task automatic wait_next_pc(input logic [`FETCH_PC_W-1:0] pc,
                              input logic [`FETCH_PC_W-1:0] exp, input string what);
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < wait_limit) begin
      drive(pc, filler_bundle(), 1'b0, 1'b0);
      #(clk_period / 4);
      seen = (branch_pc_o == exp);
      n++;
    end
    if (!seen) begin
      timeout_error(what);
    end
  endtask

  ////////////////////
  // checks
  ////////////////////
  a_reset_quiet : assert property (@(posedge clock)
    (!reset_n || $rose(reset_n)) |-> (inst_vld_o == '0 && !override_vld_o))
    else value_error("valid bits or override set around reset");

  a_next_pc : assert property (@(posedge clock) disable iff (!reset_n)
    chk_next_pc |-> (branch_pc_o == exp_next_pc))
    else value_error($sformatf("branch_pc_o differs from %h", exp_next_pc));

  a_override : assert property (@(posedge clock) disable iff (!reset_n)
    chk_ovr |-> ((override_vld_o == exp_ovr) && (!exp_ovr || override_pc_o == exp_ovr_pc)))
    else value_error($sformatf("override differs from vld %b pc %h", exp_ovr, exp_ovr_pc));

  a_inst : assert property (@(posedge clock) disable iff (!reset_n)
    chk_inst |-> ((inst_vld_o == exp_vld) && (exp_vld == '0 || inst_o == exp_inst)))
    else value_error($sformatf("inst_o or inst_vld_o wrong, expected valid %b", exp_vld));

  a_hold : assert property (@(posedge clock) disable iff (!reset_n)
    chk_hold |-> ($stable(inst_o) && $stable(inst_vld_o)))
    else value_error("decode register changed while the buffer was full");

  a_quiet : assert property (@(posedge clock) disable iff (!reset_n)
    chk_quiet |-> !override_vld_o)
    else value_error("override raised while the buffer was full");

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    int n;
    void'($urandom(35459));
    pc_f0_i = '0;
    pc_f1_i = '0;
    inst_bundle_i = '0;
    icache_stall_i = 1'b0;
    instbuf_full_i = 1'b0;
    flush_i = 1'b0;
    rt_update_i = 1'b0;
    rt_pc_i = '0;
    rt_taken_i = 1'b0;
    f1_pc = '0;
    {chk_next_pc, chk_ovr, exp_ovr, chk_inst, chk_hold, chk_quiet} = '0;
    exp_next_pc = '0;
    exp_ovr_pc = '0;
    exp_inst = '0;
    exp_vld = '0;
    {armed_next_pc, armed_ovr, armed_inst, armed_hold, armed_quiet} = '0;

    n = 0;
    while (!reset_n && n < reset_limit) begin
      @(posedge clock);
      n++;
    end
    if (!reset_n) begin
      timeout_error("reset release");
    end
    drive(64'h0, filler_bundle(), 1'b0, 1'b0);

    // no branches and a btb miss
    pc_a = 64'h0000_0000_0010_0000;
    bundle_a = filler_bundle();
    drive(pc_a, filler_bundle(), 1'b0, 1'b0);
    expect_next_pc(pc_a + 32);
    drive(pc_a + 32, bundle_a, 1'b0, 1'b0);
    expect_override(1'b0, '0);
    drive(pc_a + 64, filler_bundle(), 1'b0, 1'b0);
    expect_inst(bundle_a, 8'hff);

    // unconditional branch at slot 2 beats a later one at slot 6
    pc_b = 64'h0000_0000_0020_0100;
    tgt_b = branch_target(pc_b, 2, 40);
    bundle_b = place_word(filler_bundle(), 2, branch_word(`OP_BR, 40));
    bundle_b = place_word(bundle_b, 6, branch_word(`OP_BR, -100));
    drive(pc_b, filler_bundle(), 1'b0, 1'b0);
    expect_next_pc(pc_b + 32);
    drive(pc_b + 32, bundle_b, 1'b0, 1'b0);
    expect_override(1'b1, tgt_b);
    drive(tgt_b, filler_bundle(), 1'b0, 1'b0);
    expect_inst(bundle_b, 8'b0000_0111);
    expect_override(1'b0, '0);
    drive(tgt_b + 32, filler_bundle(), 1'b0, 1'b0);
    expect_inst('0, 8'h00);
    wait_next_pc(pc_b, tgt_b, "the btb fill of the unconditional branch");
    drive(tgt_b, bundle_b, 1'b0, 1'b0);
    expect_override(1'b0, '0);
    drive(tgt_b + 32, filler_bundle(), 1'b0, 1'b0);
    expect_inst(bundle_b, 8'b0000_0111);

    // backward conditional branch at slot 5 later retired not taken
    pc_c = 64'h0000_0000_0030_0060;
    tgt_c = branch_target(pc_c, 5, -16);
    bundle_c = place_word(filler_bundle(), 5, branch_word(`OP_BEQ, -16));
    drive(pc_c, filler_bundle(), 1'b0, 1'b0);
    expect_next_pc(pc_c + 32);
    drive(pc_c + 32, bundle_c, 1'b0, 1'b0);
    expect_override(1'b1, tgt_c);
    drive(tgt_c, filler_bundle(), 1'b0, 1'b0);
    expect_inst(bundle_c, 8'b0011_1111);
    wait_next_pc(pc_c, tgt_c, "the btb fill of the conditional branch");
    drive(pc_c + 64, filler_bundle(), 1'b0, 1'b0);
    rt_update_i = 1'b1;
    rt_pc_i = pc_c;
    rt_taken_i = 1'b0;
    wait_next_pc(pc_c, pc_c + 24, "the retire direction update");

    // buffer full holds both registers and hides the override
    pc_d = 64'h0000_0000_0040_0000;
    tgt_d = branch_target(pc_d, 0, 8);
    bundle_d = place_word(filler_bundle(), 0, branch_word(`OP_BR, 8));
    drive(pc_d, filler_bundle(), 1'b0, 1'b0);
    for (int i = 0; i < 5; i++) begin
      drive(pc_d + 32, bundle_d, 1'b1, 1'b0);
      chk_quiet = 1'b1;
      armed_quiet++;
      if (i > 0) begin
        chk_hold = 1'b1;
        armed_hold++;
      end
    end
    drive(pc_d + 32, bundle_d, 1'b0, 1'b0);
    expect_override(1'b1, tgt_d);
    drive(tgt_d, filler_bundle(), 1'b0, 1'b0);
    expect_inst(bundle_d, 8'b0000_0001);

    // flush squashes the next two bundles
    pc_e = 64'h0000_0000_0050_0000;
    bundle_e = filler_bundle();
    drive(pc_e, filler_bundle(), 1'b0, 1'b1);
    drive(pc_e + 32, filler_bundle(), 1'b0, 1'b0);
    expect_inst('0, 8'h00);
    drive(pc_e + 64, bundle_e, 1'b0, 1'b0);
    expect_inst('0, 8'h00);
    drive(pc_e + 96, filler_bundle(), 1'b0, 1'b0);
    expect_inst(bundle_e, 8'hff);
    drive(pc_e + 128, filler_bundle(), 1'b0, 1'b0);

    if (armed_next_pc == 0 || armed_ovr == 0 || armed_inst == 0 ||
        armed_hold == 0 || armed_quiet == 0) begin
      $display("some checks were never armed by the stimulus");
      end_in_failure();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/btb_wr_if.sv
verilog/btb_table.sv
verilog/btb_write_arbiter.sv
verilog/fetch_predict_f0.sv
verilog/branch_predecode.sv
verilog/fetch_top.sv
verif/clock_gen.sv
verif/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) verilog/fetch_params.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "no result in log"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
